// ==== common/watch_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Stopwatch digit definitions
//////////////////////////////////////////////////

package watch_pkg;

	// One decimal digit of the displayed time
	typedef logic [3:0] digit_t;

	// Tenths, seconds, seconds tens, minutes, minutes tens
	localparam int num_digits = 5;

	// Count range of each digit
	// Index 0 is the tenths digit and the last one is minutes tens
	localparam logic [3:0] digit_moduli [num_digits] = '{
		4'd10,  // Tenths
		4'd10,  // Seconds
		4'd6,   // Seconds tens
		4'd10,  // Minutes
		4'd6    // Minutes tens
	};

endpackage

`default_nettype wire

// ==== common/lcd_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Character LCD codes and byte layout
//////////////////////////////////////////////////

package lcd_pkg;

	// One LCD byte, sent upper nibble first over the 4-bit bus
	typedef union packed {
		logic [7:0] whole;      // Written by the sequencer
		struct packed {
			logic [3:0] upper;  // First on the bus
			logic [3:0] lower;
		} nibbles;              // Read by the nibble writer
	} lcd_byte_u;

	// Setup commands, sent with RS low
	localparam logic [7:0] cmd_function_set = 8'h28;  // 4-bit bus, two lines, 5x7 font
	localparam logic [7:0] cmd_entry_mode   = 8'h06;  // Cursor moves right, no shift
	localparam logic [7:0] cmd_display_on   = 8'h0C;  // Display on, cursor off
	localparam logic [7:0] cmd_clear        = 8'h01;  // Needs the long wait afterwards
	localparam logic [7:0] cmd_line1_addr   = 8'h80;  // DD RAM address 0x00
	localparam logic [7:0] cmd_line2_addr   = 8'hC0;  // DD RAM address 0x40

	// Character codes
	localparam logic [7:0] ascii_zero = 8'h30;  // Digit characters start here
	localparam logic [7:0] char_colon = 8'h3A;

	// Characters written per line
	localparam int line1_len = 10;
	localparam int line2_len = 12;

	// Power-on nibbles for the switch to 4-bit mode
	localparam logic [3:0] init_nibble_3 = 4'h3;
	localparam logic [3:0] init_nibble_2 = 4'h2;

endpackage

`default_nettype wire

// ==== stopwatch/tenth_tick.sv ====
`default_nettype none

// Timebase for the tenths digit
module tenth_tick #(
	parameter int tick_cycles = 5_000_000  // Clocks per 100 ms
) (
	input  logic clock,
	input  logic reset,
	output logic tick
);
	localparam int cnt_w = $clog2(tick_cycles + 1);

	logic [cnt_w-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			tick  <= 1'b0;
		end else if (count == cnt_w'(tick_cycles - 1)) begin
			count <= '0;
			tick  <= 1'b1;  // One clock wide
		end else begin
			count <= count + 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== stopwatch/digit_counter.sv ====
`default_nettype none

//////////////////////////////////////////////////
// One time digit with a carry to the next
//////////////////////////////////////////////////

module digit_counter #(
	parameter int modulus = 10  // 10 for units, 6 for tens
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              enable,  // Tick or carry of the digit below
	output watch_pkg::digit_t digit,
	output logic              carry
);
	// Highest value before the wrap
	localparam watch_pkg::digit_t last_value = watch_pkg::digit_t'(modulus - 1);

	logic at_last;

	assign at_last = (digit == last_value);

	// Same clock for every digit
	// The carry only enables the next counter
	assign carry = enable && at_last;

	always_ff @(posedge clock) begin
		if (reset) begin
			digit <= '0;
		end else if (enable) begin
			if (at_last) begin
				digit <= '0;  // Wrap
			end else begin
				digit <= digit + watch_pkg::digit_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== lcd/lcd_power_on.sv ====
`default_nettype none

// Datasheet power-on sequence for the 4-bit interface
module lcd_power_on #(
	parameter int power_wait_cycles    = 750_000,
	parameter int init_gap_long_cycles = 205_000,
	parameter int init_gap_mid_cycles  = 5_000,
	parameter int cmd_gap_cycles       = 2_000,
	parameter int hold_cycles          = 12
) (
	input  logic       clock,
	input  logic       reset,
	output logic [3:0] init_d,
	output logic       init_e,
	output logic       init_done
);
	localparam int cnt_w = $clog2(power_wait_cycles + init_gap_long_cycles
		+ init_gap_mid_cycles + cmd_gap_cycles + hold_cycles + 1);

	localparam logic [2:0] st_wait  = 3'd0;  // Display power settling
	localparam logic [2:0] st_setup = 3'd1;  // Data out, E still low
	localparam logic [2:0] st_hold  = 3'd2;
	localparam logic [2:0] st_gap   = 3'd3;
	localparam logic [2:0] st_done  = 3'd4;

	logic [2:0]       state;
	logic [cnt_w-1:0] count;     // Shared by all waits
	logic [1:0]       step;      // Which of the four writes
	logic [cnt_w-1:0] gap_last;

	// Wait after each write
	always_comb begin
		case (step)
			2'd0:    gap_last = cnt_w'(init_gap_long_cycles - 1);
			2'd1:    gap_last = cnt_w'(init_gap_mid_cycles - 1);
			default: gap_last = cnt_w'(cmd_gap_cycles - 1);
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= st_wait;
			count     <= '0;
			step      <= 2'd0;
			init_d    <= 4'h0;
			init_e    <= 1'b0;
			init_done <= 1'b0;
		end else begin
			case (state)
				st_wait: begin
					if (count == cnt_w'(power_wait_cycles - 1)) begin
						count  <= '0;
						init_d <= lcd_pkg::init_nibble_3;
						state  <= st_setup;
					end else begin
						count <= count + 1'b1;
					end
				end
				st_setup: begin
					init_e <= 1'b1;  // Data has had a cycle to settle
					state  <= st_hold;
				end
				st_hold: begin
					if (count == cnt_w'(hold_cycles - 1)) begin
						count  <= '0;
						init_e <= 1'b0;
						state  <= st_gap;
					end else begin
						count <= count + 1'b1;
					end
				end
				st_gap: begin
					if (count != gap_last) begin
						count <= count + 1'b1;  // Data kept past the fall
					end else if (step == 2'd3) begin
						count     <= '0;
						init_d    <= 4'h0;
						init_done <= 1'b1;
						state     <= st_done;
					end else begin
						count <= '0;
						step  <= step + 1'b1;
						// Three 3s and then the 2
						init_d <= (step == 2'd2) ? lcd_pkg::init_nibble_2
							: lcd_pkg::init_nibble_3;
						state <= st_setup;
					end
				end
				st_done: state <= st_done;  // Stays here until reset
				default: state <= st_wait;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lcd/lcd_sequencer.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Command list, line 1 text and the line 2 refresh loop
//////////////////////////////////////////////////

module lcd_sequencer (
	input  logic               clock,
	input  logic               reset,
	input  logic               init_done,
	input  logic               tx_done,
	input  watch_pkg::digit_t  digits [watch_pkg::num_digits],
	output logic               tx_start,
	output logic               tx_rs,
	output lcd_pkg::lcd_byte_u tx_byte
);
	// Step numbers of the byte sequence
	localparam int line1_first     = 5;  // After the five setup commands
	localparam int line2_addr_step = line1_first + lcd_pkg::line1_len;
	localparam int line2_first     = line2_addr_step + 1;
	localparam int last_step       = line2_first + lcd_pkg::line2_len - 1;
	localparam int step_w          = $clog2(last_step + 1);

	localparam logic [8*lcd_pkg::line1_len-1:0] line1_text = "Stopwatch ";  // Blank pads to ten
	localparam logic [31:0] line2_label = "Time";

	localparam logic [1:0] st_wait_init = 2'd0;
	localparam logic [1:0] st_send      = 2'd1;
	localparam logic [1:0] st_wait_done = 2'd2;

	logic [1:0]        state;
	logic [step_w-1:0] step;
	logic [3:0]        text_idx;  // Character position within the current line
	logic [7:0]        next_byte;
	logic              next_rs;
	watch_pkg::digit_t snap [watch_pkg::num_digits];  // Time shown in this frame

	function automatic logic [7:0] digit_char(input watch_pkg::digit_t d);
		return lcd_pkg::ascii_zero + {4'h0, d};
	endfunction

	assign text_idx = (step < step_w'(line2_first)) ? 4'(step - step_w'(line1_first))
		: 4'(step - step_w'(line2_first));

	// Byte and RS for the current step
	always_comb begin
		next_rs   = 1'b1;
		next_byte = lcd_pkg::char_colon;
		if (step < step_w'(line1_first)) begin
			next_rs = 1'b0;
			case (step[2:0])
				3'd0:    next_byte = lcd_pkg::cmd_function_set;
				3'd1:    next_byte = lcd_pkg::cmd_entry_mode;
				3'd2:    next_byte = lcd_pkg::cmd_display_on;
				3'd3:    next_byte = lcd_pkg::cmd_clear;
				default: next_byte = lcd_pkg::cmd_line1_addr;
			endcase
		end else if (step < step_w'(line2_addr_step)) begin
			// Leftmost character sits in the top byte
			next_byte = line1_text[8*(lcd_pkg::line1_len - 1 - int'(text_idx)) +: 8];
		end else if (step == step_w'(line2_addr_step)) begin
			next_rs   = 1'b0;
			next_byte = lcd_pkg::cmd_line2_addr;
		end else begin
			case (text_idx)
				4'd0, 4'd1, 4'd2, 4'd3: begin
					next_byte = line2_label[8*(3 - int'(text_idx)) +: 8];
				end
				4'd5:    next_byte = digit_char(snap[4]);  // Minutes tens
				4'd6:    next_byte = digit_char(snap[3]);
				4'd8:    next_byte = digit_char(snap[2]);  // Seconds tens
				4'd9:    next_byte = digit_char(snap[1]);
				4'd11:   next_byte = digit_char(snap[0]);  // Tenths
				default: next_byte = lcd_pkg::char_colon;  // Positions 4, 7 and 10
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= st_wait_init;
			step     <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				st_wait_init: begin
					if (init_done) begin
						state <= st_send;
					end
				end
				st_send: begin
					tx_start <= 1'b1;
					state    <= st_wait_done;
				end
				st_wait_done: begin
					if (tx_done) begin
						state <= st_send;
						if (step == step_w'(last_step)) begin
							step <= step_w'(line2_addr_step);  // Next frame of line 2
						end else begin
							step <= step + 1'b1;
						end
					end
				end
				default: state <= st_wait_init;
			endcase
		end
	end

	// Byte stays put until the writer reports done
	always_ff @(posedge clock) begin
		if (state == st_send) begin
			tx_byte.whole <= next_byte;
			tx_rs         <= next_rs;
			if (step == step_w'(line2_addr_step)) begin
				snap <= digits;
			end
		end
	end

endmodule

`default_nettype wire

// ==== lcd/lcd_nibble_tx.sv ====
`default_nettype none

// Sends a byte as two nibbles and owns the LCD pins
module lcd_nibble_tx #(
	parameter int setup_cycles      = 2,
	parameter int hold_cycles       = 12,
	parameter int nibble_gap_cycles = 50,
	parameter int cmd_gap_cycles    = 2_000,
	parameter int clear_wait_cycles = 82_000
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               tx_start,
	input  logic               tx_rs,
	input  lcd_pkg::lcd_byte_u tx_byte,
	input  logic [3:0]         init_d,
	input  logic               init_e,
	output logic               tx_done,
	output logic [3:0]         lcd_d,
	output logic               lcd_e,
	output logic               lcd_rs
);
	localparam int cnt_w = $clog2(setup_cycles + hold_cycles + nibble_gap_cycles
		+ cmd_gap_cycles + clear_wait_cycles + 1);

	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_setup   = 3'd1;
	localparam logic [2:0] st_hold    = 3'd2;
	localparam logic [2:0] st_gap_mid = 3'd3;  // Between the two nibbles
	localparam logic [2:0] st_gap_end = 3'd4;  // Before the next byte

	logic [2:0]         state;
	logic [cnt_w-1:0]   count;
	logic               lower;      // Second nibble in flight
	logic               e_q;
	logic [3:0]         d_q;
	logic               rs_q;
	lcd_pkg::lcd_byte_u byte_q;
	logic               start_byte;
	logic               mid_done;
	logic [cnt_w-1:0]   end_gap_last;

	assign start_byte = (state == st_idle) && tx_start;
	assign mid_done   = (state == st_gap_mid) && (count == cnt_w'(nibble_gap_cycles - 1));

	// Clear display needs the long execution time
	assign end_gap_last = (!rs_q && byte_q.whole == lcd_pkg::cmd_clear)
		? cnt_w'(clear_wait_cycles - 1) : cnt_w'(cmd_gap_cycles - 1);

	// Power-on nibbles pass through while idle
	assign lcd_d  = (state == st_idle) ? init_d : d_q;
	assign lcd_e  = (state == st_idle) ? init_e : e_q;
	assign lcd_rs = (state != st_idle) && rs_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= st_idle;
			count   <= '0;
			lower   <= 1'b0;
			e_q     <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				st_idle: begin
					if (tx_start) begin
						count <= '0;
						lower <= 1'b0;
						state <= st_setup;
					end
				end
				st_setup: begin
					if (count == cnt_w'(setup_cycles - 1)) begin
						count <= '0;
						e_q   <= 1'b1;
						state <= st_hold;
					end else begin
						count <= count + 1'b1;
					end
				end
				st_hold: begin
					if (count == cnt_w'(hold_cycles - 1)) begin
						count <= '0;
						e_q   <= 1'b0;
						state <= lower ? st_gap_end : st_gap_mid;
					end else begin
						count <= count + 1'b1;
					end
				end
				st_gap_mid: begin
					if (mid_done) begin
						count <= '0;
						lower <= 1'b1;
						state <= st_setup;
					end else begin
						count <= count + 1'b1;
					end
				end
				st_gap_end: begin
					if (count == end_gap_last) begin
						count   <= '0;
						tx_done <= 1'b1;
						state   <= st_idle;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Byte, RS and the nibble on the pins
	always_ff @(posedge clock) begin
		if (start_byte) begin
			byte_q <= tx_byte;
			rs_q   <= tx_rs;
			d_q    <= tx_byte.nibbles.upper;  // Upper nibble goes first
		end else if (mid_done) begin
			d_q <= byte_q.nibbles.lower;
		end
	end

endmodule

`default_nettype wire

// ==== design/stopwatch_top.sv ====
`default_nettype none

module stopwatch_top #(
	parameter int tick_cycles          = 5_000_000,  // 100 ms at 50 MHz
	parameter int power_wait_cycles    = 750_000,    // 15 ms
	parameter int init_gap_long_cycles = 205_000,    // 4.1 ms
	parameter int init_gap_mid_cycles  = 5_000,      // 100 us
	parameter int cmd_gap_cycles       = 2_000,      // 40 us
	parameter int clear_wait_cycles    = 82_000,     // 1.64 ms
	parameter int setup_cycles         = 2,
	parameter int hold_cycles          = 12,         // E high time
	parameter int nibble_gap_cycles    = 50          // 1 us between nibbles
) (
	input  logic       clock,
	input  logic       reset,
	output logic [3:0] lcd_d,
	output logic       lcd_e,
	output logic       lcd_rs
);
	logic tick;
	logic [watch_pkg::num_digits-1:0] carry;
	logic [watch_pkg::num_digits-1:0] digit_enable;
	watch_pkg::digit_t digits [watch_pkg::num_digits];

	logic [3:0]         init_d;
	logic               init_e;
	logic               init_done;
	logic               tx_start;
	logic               tx_rs;
	logic               tx_done;
	lcd_pkg::lcd_byte_u tx_byte;

	//////////////////////////////////////////////////
	// Time base and digit chain
	//////////////////////////////////////////////////

	tenth_tick #(
		.tick_cycles(tick_cycles)
	) i_tenth_tick (
		.clock(clock),
		.reset(reset),
		.tick (tick)
	);

	// Each digit counts on the carry of the one below
	assign digit_enable = {carry[watch_pkg::num_digits-2:0], tick};

	for (genvar i = 0; i < watch_pkg::num_digits; i++) begin : g_digit
		digit_counter #(
			.modulus(watch_pkg::digit_moduli[i])
		) i_digit_counter (
			.clock (clock),
			.reset (reset),
			.enable(digit_enable[i]),
			.digit (digits[i]),
			.carry (carry[i])
		);
	end

	//////////////////////////////////////////////////
	// LCD side
	//////////////////////////////////////////////////

	lcd_power_on #(
		.power_wait_cycles   (power_wait_cycles),
		.init_gap_long_cycles(init_gap_long_cycles),
		.init_gap_mid_cycles (init_gap_mid_cycles),
		.cmd_gap_cycles      (cmd_gap_cycles),
		.hold_cycles         (hold_cycles)
	) i_lcd_power_on (
		.clock    (clock),
		.reset    (reset),
		.init_d   (init_d),
		.init_e   (init_e),
		.init_done(init_done)
	);

	lcd_sequencer i_lcd_sequencer (
		.clock    (clock),
		.reset    (reset),
		.init_done(init_done),
		.tx_done  (tx_done),
		.digits   (digits),
		.tx_start (tx_start),
		.tx_rs    (tx_rs),
		.tx_byte  (tx_byte)
	);

	lcd_nibble_tx #(
		.setup_cycles     (setup_cycles),
		.hold_cycles      (hold_cycles),
		.nibble_gap_cycles(nibble_gap_cycles),
		.cmd_gap_cycles   (cmd_gap_cycles),
		.clear_wait_cycles(clear_wait_cycles)
	) i_lcd_nibble_tx (
		.clock   (clock),
		.reset   (reset),
		.tx_start(tx_start),
		.tx_rs   (tx_rs),
		.tx_byte (tx_byte),
		.init_d  (init_d),
		.init_e  (init_e),
		.tx_done (tx_done),
		.lcd_d   (lcd_d),
		.lcd_e   (lcd_e),
		.lcd_rs  (lcd_rs)
	);

endmodule

`default_nettype wire

// ==== test/lcd_bus_monitor.sv ====
`default_nettype none

// Rebuilds nibbles and bytes from the LCD pins
module lcd_bus_monitor #(
	parameter int init_pulses = 4  // Single nibbles before pairing starts
) (
	input logic       clock,
	input logic       reset,
	input logic [3:0] lcd_d,
	input logic       lcd_e,
	input logic       lcd_rs
);
	// Power-on pulses, one entry each
	logic [3:0] init_nibble [$];
	logic       init_rs [$];
	int         init_width [$];
	longint     init_gap [$];  // Low samples before the rise

	// Paired bytes, upper nibble first
	logic [7:0] byte_val [$];
	logic       byte_rs [$];
	longint     byte_gap [$];   // Low samples before the upper nibble
	longint     byte_rise [$];  // Cycle of the upper nibble rise

	// Over the whole run
	int     min_width;
	int     max_width;
	longint min_inner_gap;   // Between the two nibbles of a byte
	int     unstable_count;  // Data or RS moved around a pulse

	longint     cycle;  // Samples since reset went low
	longint     rise_cycle;
	longint     fall_cycle;
	longint     pulse_gap;
	int         pulse_count;
	logic       e_q;
	logic [3:0] d_q;
	logic [3:0] nibble;
	logic       rs_at_rise;
	logic       have_upper;
	logic [3:0] upper;
	logic       upper_rs;
	longint     upper_gap;
	longint     upper_rise;

	always @(posedge clock) begin
		int width;
		if (reset) begin
			cycle          = 0;
			fall_cycle     = 1;  // First sample after reset
			pulse_count    = 0;
			have_upper     = 1'b0;
			e_q            = 1'b0;
			d_q            = 4'h0;
			min_width      = 1 << 30;
			max_width      = 0;
			min_inner_gap  = 1 << 30;
			unstable_count = 0;
		end else begin
			cycle = cycle + 1;
			if (lcd_e && !e_q) begin
				rise_cycle = cycle;
				pulse_gap  = cycle - fall_cycle;
				nibble     = lcd_d;
				rs_at_rise = lcd_rs;
				if (lcd_d !== d_q) begin
					unstable_count++;  // No setup before the rise
				end
			end else if (lcd_e) begin
				if (lcd_d !== nibble || lcd_rs !== rs_at_rise) begin
					unstable_count++;
				end
			end else if (e_q) begin
				width = int'(cycle - rise_cycle);
				if (width < min_width) min_width = width;
				if (width > max_width) max_width = width;
				if (pulse_count < init_pulses) begin
					init_nibble.push_back(nibble);
					init_rs.push_back(rs_at_rise);
					init_width.push_back(width);
					init_gap.push_back(pulse_gap);
				end else if (!have_upper) begin
					upper      = nibble;
					upper_rs   = rs_at_rise;
					upper_gap  = pulse_gap;
					upper_rise = rise_cycle;
					have_upper = 1'b1;
				end else begin
					byte_val.push_back({upper, nibble});
					byte_rs.push_back(upper_rs);
					byte_gap.push_back(upper_gap);
					byte_rise.push_back(upper_rise);
					if (pulse_gap < min_inner_gap) min_inner_gap = pulse_gap;
					if (rs_at_rise !== upper_rs) unstable_count++;  // RS split inside a byte
					have_upper = 1'b0;
				end
				pulse_count++;
				fall_cycle = cycle;
			end
			e_q = lcd_e;
			d_q = lcd_d;
		end
	end

endmodule

`default_nettype wire

// ==== test/stopwatch_tb.sv ====
`default_nettype none

module stopwatch_tb;
	// Small timing so the full hour wraps in a short run
	localparam int tick_cycles          = 10;
	localparam int power_wait_cycles    = 20;
	localparam int init_gap_long_cycles = 15;
	localparam int init_gap_mid_cycles  = 8;
	localparam int cmd_gap_cycles       = 5;
	localparam int clear_wait_cycles    = 30;
	localparam int setup_cycles         = 2;
	localparam int hold_cycles          = 3;
	localparam int nibble_gap_cycles    = 4;

	localparam int wait_limit = 2_000;   // Cycles for any single wait
	localparam int hour_ticks = 36_000;  // 60 minutes in tenths
	localparam int max_frames = 2_000;
	localparam int max_step   = 100;     // Upper bound on ticks between two frames

	logic       clock;
	logic       reset;
	logic [3:0] lcd_d;
	logic       lcd_e;
	logic       lcd_rs;

	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int test_start_errors;

	stopwatch_top #(
		.tick_cycles         (tick_cycles),
		.power_wait_cycles   (power_wait_cycles),
		.init_gap_long_cycles(init_gap_long_cycles),
		.init_gap_mid_cycles (init_gap_mid_cycles),
		.cmd_gap_cycles      (cmd_gap_cycles),
		.clear_wait_cycles   (clear_wait_cycles),
		.setup_cycles        (setup_cycles),
		.hold_cycles         (hold_cycles),
		.nibble_gap_cycles   (nibble_gap_cycles)
	) i_stopwatch_top (
		.clock (clock),
		.reset (reset),
		.lcd_d (lcd_d),
		.lcd_e (lcd_e),
		.lcd_rs(lcd_rs)
	);

	lcd_bus_monitor monitor (
		.clock (clock),
		.reset (reset),
		.lcd_d (lcd_d),
		.lcd_e (lcd_e),
		.lcd_rs(lcd_rs)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Bookkeeping and queue access
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		errors++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors != test_start_errors) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - test_start_errors);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic wait_init_pulses(input int count, output bit ok);
		int waited;
		waited = 0;
		while (monitor.init_nibble.size() < count && waited < wait_limit) begin
			@(posedge clock);
			waited++;
		end
		ok = (monitor.init_nibble.size() >= count);
	endtask

	task automatic wait_bytes(input int count, output bit ok);
		int waited;
		waited = 0;
		while (monitor.byte_val.size() < count && waited < wait_limit) begin
			@(posedge clock);
			waited++;
		end
		ok = (monitor.byte_val.size() >= count);
	endtask

	task automatic pop_byte(output logic [7:0] value, output logic rs, output longint gap,
		output longint rise);
		value = monitor.byte_val.pop_front();
		rs    = monitor.byte_rs.pop_front();
		gap   = monitor.byte_gap.pop_front();
		rise  = monitor.byte_rise.pop_front();
	endtask

	function automatic bit is_digit_char(input logic [7:0] c);
		return c >= 8'h30 && c <= 8'h39;
	endfunction

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	// Three 3s then a 2 with RS low
	task automatic check_power_on();
		bit         ok;
		logic [3:0] expected;
		wait_init_pulses(4, ok);
		if (!ok) begin
			report_timeout("the four power-on pulses");
			return;
		end
		if (monitor.init_gap[0] < power_wait_cycles) begin
			report_mismatch($sformatf("E rose %0d cycles after reset", monitor.init_gap[0]));
		end
		for (int i = 0; i < 4; i++) begin
			expected = (i == 3) ? 4'h2 : 4'h3;
			if (monitor.init_nibble[i] !== expected) begin
				report_mismatch($sformatf("power-on nibble %0d is %h, expected %h", i,
					monitor.init_nibble[i], expected));
			end
			if (monitor.init_rs[i] !== 1'b0) begin
				report_mismatch($sformatf("power-on nibble %0d sent with RS high", i));
			end
			if (monitor.init_width[i] != hold_cycles) begin
				report_mismatch($sformatf("power-on pulse %0d is %0d cycles wide", i,
					monitor.init_width[i]));
			end
		end
	endtask

	task automatic check_setup_commands();
		bit         ok;
		logic [7:0] value;
		logic       rs;
		longint     gap;
		longint     rise;
		logic [7:0] expected [5];
		expected = '{8'h28, 8'h06, 8'h0C, 8'h01, 8'h80};
		wait_bytes(5, ok);
		if (!ok) begin
			report_timeout("the five setup commands");
			return;
		end
		for (int i = 0; i < 5; i++) begin
			pop_byte(value, rs, gap, rise);
			if (value !== expected[i] || rs !== 1'b0) begin
				report_mismatch($sformatf("command %0d is %h rs %b, expected %h rs 0", i,
					value, rs, expected[i]));
			end
			// Gap before the address byte follows the clear
			if (i == 4 && gap < clear_wait_cycles) begin
				report_mismatch($sformatf("only %0d idle cycles after clear", gap));
			end
		end
	endtask

	task automatic check_line1();
		bit         ok;
		logic [7:0] value;
		logic       rs;
		longint     gap;
		longint     rise;
		string      text;
		text = "Stopwatch ";  // Ten characters with a blank pad
		wait_bytes(11, ok);
		if (!ok) begin
			report_timeout("the line 1 text");
			return;
		end
		for (int i = 0; i < 10; i++) begin
			pop_byte(value, rs, gap, rise);
			if (value !== text[i] || rs !== 1'b1) begin
				report_mismatch($sformatf("line 1 char %0d is %h rs %b, expected %h rs 1", i,
					value, rs, text[i]));
			end
		end
		// Left in the queue for the first frame
		if (monitor.byte_val[0] !== 8'hC0 || monitor.byte_rs[0] !== 1'b0) begin
			report_mismatch($sformatf("byte after line 1 is %h, expected C0 with RS low",
				monitor.byte_val[0]));
		end
	endtask

	// Reads one line 2 frame as tenths within the hour
	task automatic read_frame(output int tenths, output longint frame_rise, output bit ok);
		logic [7:0] c [12];
		logic [7:0] value;
		logic       rs;
		longint     gap;
		longint     rise;
		string      label;
		label  = "Time:";
		tenths = 0;
		wait_bytes(13, ok);
		if (!ok) begin
			report_timeout("a line 2 frame");
			return;
		end
		pop_byte(value, rs, gap, frame_rise);
		if (value !== 8'hC0 || rs !== 1'b0) begin
			report_mismatch($sformatf("frame starts with %h rs %b, expected C0 rs 0", value, rs));
		end
		for (int i = 0; i < 12; i++) begin
			pop_byte(c[i], rs, gap, rise);
			if (rs !== 1'b1) begin
				report_mismatch($sformatf("frame char %0d sent with RS low", i));
			end
		end
		for (int i = 0; i < 5; i++) begin
			if (c[i] !== label[i]) begin
				report_mismatch($sformatf("label char %0d is %h, expected %h", i, c[i], label[i]));
			end
		end
		if (c[7] !== 8'h3A || c[10] !== 8'h3A) begin
			report_mismatch($sformatf("separators are %h and %h, expected colons", c[7], c[10]));
		end
		if (!is_digit_char(c[5]) || !is_digit_char(c[6]) || !is_digit_char(c[8])
			|| !is_digit_char(c[9]) || !is_digit_char(c[11])) begin
			report_mismatch("time field holds a non-digit");
		end else if (c[5] > 8'h35 || c[8] > 8'h35) begin
			report_mismatch($sformatf("tens digits %h and %h above 5", c[5], c[8]));
		end else begin
			tenths = ((int'(c[5] - 8'h30) * 10 + int'(c[6] - 8'h30)) * 60
				+ int'(c[8] - 8'h30) * 10 + int'(c[9] - 8'h30)) * 10 + int'(c[11] - 8'h30);
		end
	endtask

	task automatic check_frame_format();
		int     tenths;
		longint rise;
		bit     ok;
		for (int i = 0; i < 5; i++) begin
			read_frame(tenths, rise, ok);
			if (!ok) return;
		end
	endtask

	// Displayed time against elapsed ticks through the hour wrap
	task automatic check_counting();
		int     prev;
		int     cur;
		int     expected;
		int     diff;
		int     delta;
		int     frames;
		int     after_wrap;
		longint rise;
		bit     ok;
		bit     wrapped;
		prev       = -1;
		frames     = 0;
		after_wrap = 0;
		wrapped    = 1'b0;
		while (frames < max_frames && after_wrap < 3) begin
			read_frame(cur, rise, ok);
			if (!ok) return;
			frames++;
			expected = int'((rise / tick_cycles) % hour_ticks);
			diff     = (cur - expected + hour_ticks) % hour_ticks;
			if (diff != 0 && diff != 1 && diff != hour_ticks - 1) begin
				report_mismatch($sformatf("shows %0d tenths, expected about %0d", cur, expected));
			end
			if (prev >= 0) begin
				delta = (cur - prev + hour_ticks) % hour_ticks;
				if (delta == 0 || delta > max_step) begin
					report_mismatch($sformatf("time went from %0d to %0d tenths", prev, cur));
				end
				if (cur < prev) wrapped = 1'b1;  // 59:59.9 rolled over
			end
			if (wrapped) after_wrap++;
			prev = cur;
		end
		if (!wrapped) begin
			$display("The time never wrapped past 59:59.9 within %0d frames", frames);
			errors++;
		end
	endtask

	task automatic check_bus_timing();
		if (monitor.min_width != hold_cycles || monitor.max_width != hold_cycles) begin
			report_mismatch($sformatf("E pulses from %0d to %0d cycles, expected %0d",
				monitor.min_width, monitor.max_width, hold_cycles));
		end
		if (monitor.min_inner_gap < nibble_gap_cycles + setup_cycles) begin
			report_mismatch($sformatf("nibbles of a byte only %0d cycles apart",
				monitor.min_inner_gap));
		end
		if (monitor.unstable_count != 0) begin
			report_mismatch($sformatf("%0d pulses with data or RS moving",
				monitor.unstable_count));
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		test_start_errors = errors;
		check_power_on();
		close_test("power_on");

		test_start_errors = errors;
		check_setup_commands();
		close_test("setup_commands");

		test_start_errors = errors;
		check_line1();
		close_test("line1_text");

		test_start_errors = errors;
		check_frame_format();
		close_test("frame_format");

		test_start_errors = errors;
		check_counting();
		close_test("counting");

		test_start_errors = errors;
		check_bus_timing();
		close_test("bus_timing");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
common/watch_pkg.sv
common/lcd_pkg.sv
stopwatch/tenth_tick.sv
stopwatch/digit_counter.sv
lcd/lcd_power_on.sv
lcd/lcd_sequencer.sv
lcd/lcd_nibble_tx.sv
design/stopwatch_top.sv
test/lcd_bus_monitor.sv
test/stopwatch_tb.sv
